// File: flist.f
verilog/tlu_cfg_pkg.sv
verilog/tlu_event_pkg.sv
verilog/tlu_handshake_fsm.sv
verilog/tlu_serial_capture.sv
verilog/tlu_event_output.sv
verilog/tlu_controller_top.sv
test/tlu_beam_model.sv
test/tlu_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TLU controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tlu_controller_tb \
    -f flist.f --Mdir obj_dir -o tlu_sim

./obj_dir/tlu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    echo "TEST FAILED"
    exit 1
fi
echo "TEST PASSED"

// File: test/tlu_controller_tb.sv
/*
 * TLU controller testbench
 * Applies a table of trigger cases in all four modes, checks the
 * start flag, busy, veto, error flags, serial trigger number and the
 * FIFO word, and reports an error count at the end.
 */

`timescale 1ns/1ps

module tlu_controller_tb
    import tlu_cfg_pkg::*;
    import tlu_event_pkg::*;
();

    localparam int          DIVISOR     = 4;
    localparam int          NUM_CASES   = 12;
    localparam int          PERIOD_NS   = 100;
    localparam longint      WATCHDOG_NS = longint'(NUM_CASES) * 600 * PERIOD_NS;
    localparam int unsigned SEED        = 32'h2557b189;

    // exp bits: accept, veto while idle, low timeout error, accept error
    typedef struct packed {
        logic [1:0] mode;
        logic [4:0] clock_cycles;
        logic [3:0] data_delay;
        logic       msb_first;
        logic       write_ts;
        logic [7:0] low_timeout;
        logic       near_full;
        logic       disable_veto;
        logic       enable;
        logic [7:0] hold;
        logic [7:0] ready_delay;
        logic [7:0] read_wait;
        logic [3:0] exp;
    } case_t;

    logic            CLK;
    logic            RESET;
    tlu_cfg_t        cfg;
    logic            cmd_ready;
    logic            ext_start_enable;
    logic            ext_veto;
    logic            fifo_near_full;
    logic            tb_trigger;
    logic            tlu_line;
    logic            tlu_trigger;
    logic            tlu_trigger_flag;
    logic            fifo_read;
    logic            fifo_empty;
    fifo_word_t      fifo_data;
    logic            fifo_preempt_req;
    trigger_number_t trigger_number;
    logic            trigger_number_ready;
    logic            cmd_ext_start_flag;
    tlu_status_t     status;
    tlu_error_t      err_flags;
    logic [5:0]      frame_n;
    logic [31:0]     beam_number;
    int              cyc;
    int              value_errs;
    int              other_errs;
    case_t           cases [NUM_CASES];

    assign tlu_trigger = tb_trigger | tlu_line;

    tlu_controller_top #(
        .DIVISOR (DIVISOR)
    ) u_dut (
        .CLK                  (CLK),
        .RESET                (RESET),
        .cfg                  (cfg),
        .cmd_ready            (cmd_ready),
        .ext_start_enable     (ext_start_enable),
        .ext_veto             (ext_veto),
        .fifo_near_full       (fifo_near_full),
        .tlu_trigger          (tlu_trigger),
        .tlu_trigger_flag     (tlu_trigger_flag),
        .fifo_read            (fifo_read),
        .fifo_empty           (fifo_empty),
        .fifo_data            (fifo_data),
        .fifo_preempt_req     (fifo_preempt_req),
        .trigger_number       (trigger_number),
        .trigger_number_ready (trigger_number_ready),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .status               (status),
        .errors               (err_flags)
    );

    tlu_beam_model #(
        .DIVISOR (DIVISOR)
    ) u_tlu (
        .CLK          (CLK),
        .clock_enable (status.clock_enable),
        .frame_bits   (frame_n),
        .data_delay   (cfg.data_delay),
        .msb_first    (cfg.msb_first),
        .number       (beam_number),
        .line         (tlu_line)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // edges since reset release, reference for the timestamp
    always @(posedge CLK)
    begin
        if (RESET)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    task automatic tick();
        @(posedge CLK);
        #10;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            $display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else
        begin
            $display("Failure at %0d ns: %s", $time, what);
            other_errs++;
        end
    endtask

    task automatic load_table();
        //          md    cc    dd    msb   wts   lowto nf    dv    en    hold  rdy   rdw   exp
        cases[0]  = '{2'd0, 5'd0, 4'd0, 1'b0, 1'b1, 8'd0, 1'b0, 1'b0, 1'b1, 8'd0, 8'd0, 8'd0, 4'b1000};
        cases[1]  = '{2'd1, 5'd0, 4'd0, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd0, 8'd0, 8'd0, 4'b1000};
        cases[2]  = '{2'd2, 5'd0, 4'd0, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd30, 8'd0, 8'd0, 4'b1000};
        cases[3]  = '{2'd2, 5'd0, 4'd0, 1'b0, 1'b1, 8'd10, 1'b0, 1'b0, 1'b1, 8'd40, 8'd0, 8'd0, 4'b1010};
        cases[4]  = '{2'd3, 5'd8, 4'd2, 1'b1, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd5, 8'd0, 8'd0, 4'b1000};
        cases[5]  = '{2'd3, 5'd8, 4'd0, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd3, 8'd0, 8'd2, 4'b1000};
        cases[6]  = '{2'd3, 5'd0, 4'd5, 1'b1, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd4, 8'd0, 8'd0, 4'b1000};
        cases[7]  = '{2'd3, 5'd0, 4'd1, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b1, 8'd2, 8'd0, 8'd0, 4'b1000};
        cases[8]  = '{2'd0, 5'd0, 4'd0, 1'b0, 1'b1, 8'd0, 1'b1, 1'b0, 1'b1, 8'd0, 8'd0, 8'd0, 4'b1100};
        cases[9]  = '{2'd0, 5'd0, 4'd0, 1'b0, 1'b0, 8'd0, 1'b1, 1'b1, 1'b1, 8'd0, 8'd0, 8'd0, 4'b1000};
        cases[10] = '{2'd0, 5'd0, 4'd0, 1'b0, 1'b1, 8'd0, 1'b0, 1'b0, 1'b0, 8'd0, 8'd0, 8'd0, 4'b0100};
        cases[11] = '{2'd2, 5'd0, 4'd0, 1'b0, 1'b1, 8'd0, 1'b0, 1'b0, 1'b1, 8'd10, 8'd6, 8'd25, 4'b1001};
    endtask

    task automatic run_case(input int idx, input case_t row);
        tlu_mode_e   mode;
        int          n;
        int          hold;
        int          rdy_dly;
        int          read_at;
        int          c;
        int          flags;
        int          ce_cycles;
        int          ready_pulses;
        int          busy_cycles;
        logic        done;
        logic        read_done;
        logic        word_seen;
        logic        timeout_seen;
        logic        acc_err_seen;
        logic        wants_word;
        logic [31:0] ts_exp;
        logic [31:0] tn_exp;

        mode    = tlu_mode_e'(row.mode);
        n       = (row.clock_cycles == 5'd0) ? 32 : int'(row.clock_cycles);
        hold    = int'(row.hold);
        rdy_dly = int'(row.ready_delay);
        read_at = hold + int'(row.read_wait) + int'($urandom % 32'd4);
        beam_number = $urandom;
        // receiver keeps n-1 bits of the frame
        tn_exp     = beam_number & ((32'd1 << (n - 1)) - 32'd1);
        ts_exp     = '0;
        wants_word = row.exp[3] && (row.write_ts || mode == TLU_DATA_HANDSHAKE);
        $display("case %0d: mode %0d, %0d bits", idx, row.mode, n);

        cfg.mode            = mode;
        cfg.low_timeout     = row.low_timeout;
        cfg.clock_cycles    = row.clock_cycles;
        cfg.data_delay      = row.data_delay;
        cfg.msb_first       = row.msb_first;
        cfg.disable_veto    = row.disable_veto;
        cfg.write_timestamp = row.write_ts;
        frame_n             = 6'(n);
        fifo_near_full      = row.near_full;
        ext_start_enable    = row.enable;
        cmd_ready           = (rdy_dly == 0);
        repeat (3) tick();
        check_bit("status.veto", row.exp[2], status.veto);

        if (mode == TLU_SIMPLE_HANDSHAKE || mode == TLU_DATA_HANDSHAKE)
            tb_trigger = 1'b1;
        else
            tlu_trigger_flag = 1'b1;

        c = 0;
        flags = 0;
        ce_cycles = 0;
        ready_pulses = 0;
        busy_cycles = 0;
        done = 1'b0;
        read_done = 1'b0;
        word_seen = 1'b0;
        timeout_seen = 1'b0;
        acc_err_seen = 1'b0;
        while (!done)
        begin
            tick();
            c++;
            tlu_trigger_flag = 1'b0;
            fifo_read = 1'b0;
            if (cmd_ext_start_flag)
            begin
                flags++;
                ts_exp = 32'(cyc);
                check_true(status.busy, "busy low while the start flag is high");
                check_true(c > rdy_dly, "trigger accepted while cmd_ready was low");
            end
            if (status.busy)
                busy_cycles++;
            if (status.clock_enable)
                ce_cycles++;
            if (err_flags.low_timeout_error)
                timeout_seen = 1'b1;
            if (err_flags.accept_error)
                acc_err_seen = 1'b1;
            if (trigger_number_ready)
            begin
                ready_pulses++;
                check_word("trigger_number", tn_exp, trigger_number);
            end
            if (!fifo_empty)
                word_seen = 1'b1;
            if (!fifo_empty && !read_done && c >= read_at)
            begin
                check_bit("fifo_data.marker", 1'b1, fifo_data.marker);
                if (mode == TLU_DATA_HANDSHAKE)
                    check_word("fifo_data.payload", {1'b0, tn_exp[30:0]}, {1'b0, fifo_data.payload});
                else
                    check_word("fifo_data.payload", ts_exp, {1'b0, fifo_data.payload});
                check_bit("fifo_preempt_req", 1'b1, fifo_preempt_req);
                fifo_read = 1'b1;
                read_done = 1'b1;
            end
            // without a timeout the handshake must last as long as the line is high
            if (mode == TLU_SIMPLE_HANDSHAKE && row.low_timeout == 8'd0 && flags > 0 &&
                c <= hold)
                check_true(status.busy, "busy fell while the trigger line was still high");
            if (c == hold)
                tb_trigger = 1'b0;
            if (c == rdy_dly)
                cmd_ready = 1'b1;
            if (row.exp[3])
                done = (flags > 0) && !status.busy;
            else
                done = (c >= 20);
        end

        fifo_read = 1'b0;
        tb_trigger = 1'b0;
        check_word("cmd_ext_start_flag cycles", row.exp[3] ? 32'd1 : 32'd0, 32'(flags));
        check_bit("errors.low_timeout_error seen", row.exp[1], timeout_seen);
        check_bit("errors.accept_error seen", row.exp[0], acc_err_seen);
        check_bit("FIFO word offered", wants_word, word_seen);
        check_bit("fifo_preempt_req", 1'b0, fifo_preempt_req);
        if (wants_word)
            check_true(read_done, "FIFO word was never read");
        if (mode == TLU_DATA_HANDSHAKE && row.exp[3])
        begin
            check_word("clock_enable cycles", 32'(n * DIVISOR), 32'(ce_cycles));
            check_word("trigger_number_ready pulses", 32'd1, 32'(ready_pulses));
        end
        if (row.read_wait >= 8'd20)
            check_true(busy_cycles >= 20, "busy released under FIFO back-pressure");
        repeat (2) tick();
    endtask

    initial
    begin
        value_errs = 0;
        other_errs = 0;
        void'($urandom(SEED));
        RESET = 1'b1;
        cfg = '0;
        cmd_ready = 1'b1;
        ext_start_enable = 1'b1;
        ext_veto = 1'b0;
        fifo_near_full = 1'b0;
        tb_trigger = 1'b0;
        tlu_trigger_flag = 1'b0;
        fifo_read = 1'b0;
        frame_n = 6'd32;
        beam_number = '0;
        load_table();

        repeat (8) @(posedge CLK);
        #10;
        RESET = 1'b0;
        check_word("status", 32'd0, 32'(status));
        check_word("errors", 32'd0, 32'(err_flags));
        check_bit("cmd_ext_start_flag", 1'b0, cmd_ext_start_flag);
        check_bit("fifo_preempt_req", 1'b0, fifo_preempt_req);
        check_bit("fifo_empty", 1'b1, fifo_empty);

        for (int i = 0; i < NUM_CASES; i++)
            run_case(i, cases[i]);

        $display("check summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // limit is 600 cycles per table row
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the trigger cases did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: test/tlu_beam_model.sv
/*
 * Behavioural TLU
 * Shifts a trigger number onto the trigger line once the TLU clock
 * is enabled. Each bit is held over a full DIVISOR-cycle slot and
 * the frame ends on the edge before the controller latches it.
 */

`timescale 1ns/1ps

module tlu_beam_model #(
    parameter int DIVISOR = 12
) (
    input  logic        CLK,
    input  logic        clock_enable,
    input  logic [5:0]  frame_bits,
    input  logic [3:0]  data_delay,
    input  logic        msb_first,
    input  logic [31:0] number,
    output logic        line
);

    // line level for the sample taken i cycles before the latch edge
    function automatic logic slot_level(input int i);
        int   n;
        int   slot;
        logic level;
        n = int'(frame_bits);
        slot = i / DIVISOR;
        if (slot >= n)
            level = 1'b0;
        else if (slot == n - 1)
            level = 1'b1;
        else if (msb_first)
            level = number[slot];
        else
            level = number[n - 2 - slot];
        return level;
    endfunction

    initial
    begin
        int lat;
        line = 1'b0;
        forever
        begin
            @(posedge clock_enable);
            // edges from clock start up to the one before the latch
            lat = int'(frame_bits) * DIVISOR + int'(data_delay) + 4;
            for (int e = 0; e < lat; e++)
            begin
                #10;
                line = slot_level(lat - 1 - e);
                @(posedge CLK);
            end
            #10;
            line = 1'b0;
        end
    end

endmodule

// File: verilog/tlu_controller_top.sv
/*
 * TLU controller top level
 * Connects the handshake FSM, the serial trigger-number capture and
 * the FIFO word output stage.
 */

`timescale 1ns/1ps

module tlu_controller_top
    import tlu_cfg_pkg::*;
    import tlu_event_pkg::*;
#(
    parameter int DIVISOR = 12
) (
    input  logic            CLK,
    input  logic            RESET,
    input  tlu_cfg_t        cfg,
    input  logic            cmd_ready,
    input  logic            ext_start_enable,
    input  logic            ext_veto,
    input  logic            fifo_near_full,
    input  logic            tlu_trigger,
    input  logic            tlu_trigger_flag,
    input  logic            fifo_read,
    output logic            fifo_empty,
    output fifo_word_t      fifo_data,
    output logic            fifo_preempt_req,
    output trigger_number_t trigger_number,
    output logic            trigger_number_ready,
    output logic            cmd_ext_start_flag,
    output tlu_status_t     status,
    output tlu_error_t      errors
);

    logic start_strobe;
    logic latch_strobe;
    logic word_pending;

    tlu_handshake_fsm #(
        .DIVISOR (DIVISOR)
    ) u_fsm (
        .CLK                (CLK),
        .RESET              (RESET),
        .cfg                (cfg),
        .cmd_ready          (cmd_ready),
        .ext_start_enable   (ext_start_enable),
        .ext_veto           (ext_veto),
        .fifo_near_full     (fifo_near_full),
        .tlu_trigger        (tlu_trigger),
        .tlu_trigger_flag   (tlu_trigger_flag),
        .word_pending       (word_pending),
        .cmd_ext_start_flag (cmd_ext_start_flag),
        .start_strobe       (start_strobe),
        .latch_strobe       (latch_strobe),
        .status             (status),
        .errors             (errors)
    );

    tlu_serial_capture #(
        .DIVISOR (DIVISOR)
    ) u_capture (
        .CLK                  (CLK),
        .tlu_trigger          (tlu_trigger),
        .latch_strobe         (latch_strobe),
        .cfg                  (cfg),
        .trigger_number       (trigger_number),
        .trigger_number_ready (trigger_number_ready)
    );

    tlu_event_output u_output (
        .CLK              (CLK),
        .RESET            (RESET),
        .cfg              (cfg),
        .start_strobe     (start_strobe),
        .latch_strobe     (latch_strobe),
        .trigger_number   (trigger_number),
        .fifo_read        (fifo_read),
        .word_pending     (word_pending),
        .fifo_empty       (fifo_empty),
        .fifo_data        (fifo_data),
        .fifo_preempt_req (fifo_preempt_req)
    );

endmodule

// File: verilog/tlu_event_output.sv
/*
 * TLU event output
 * Free-running timestamp, capture at trigger start and the single
 * word offered to the readout FIFO together with its preempt request.
 */

`timescale 1ns/1ps

module tlu_event_output
    import tlu_cfg_pkg::*;
    import tlu_event_pkg::*;
(
    input  logic            CLK,
    input  logic            RESET,
    input  tlu_cfg_t        cfg,
    input  logic            start_strobe,
    input  logic            latch_strobe,
    input  trigger_number_t trigger_number,
    input  logic            fifo_read,
    output logic            word_pending,
    output logic            fifo_empty,
    output fifo_word_t      fifo_data,
    output logic            fifo_preempt_req
);

    timestamp_t timestamp;
    timestamp_t timestamp_data;
    logic       data_mode;
    logic       set_pending;
    logic       set_preempt;

    assign data_mode = (cfg.mode == TLU_DATA_HANDSHAKE);

    // trigger number is ready one cycle after the latch, same as this flag
    assign set_pending = (start_strobe && cfg.write_timestamp && !data_mode) || latch_strobe;
    assign set_preempt = start_strobe && (data_mode || cfg.write_timestamp);

    always_ff @(posedge CLK)
    begin
        if (RESET)
            timestamp <= '0;
        else
            timestamp <= timestamp + 31'd1;
    end

    always_ff @(posedge CLK)
    begin
        if (start_strobe)
            timestamp_data <= timestamp;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            word_pending     <= 1'b0;
            fifo_preempt_req <= 1'b0;
        end
        else
        begin
            if (set_pending)
                word_pending <= 1'b1;
            else if (fifo_read)
                word_pending <= 1'b0;

            if (set_preempt)
                fifo_preempt_req <= 1'b1;
            else if (fifo_read)
                fifo_preempt_req <= 1'b0;
        end
    end

    assign fifo_empty = ~word_pending;

    always_comb
    begin
        fifo_data.marker  = 1'b1;
        fifo_data.payload = data_mode ? trigger_number[30:0] : timestamp_data;
    end

    a_no_double_pending: assert property (
        @(posedge CLK) disable iff (RESET) set_pending |-> !word_pending
    ) else $error("new FIFO word while previous word still pending");

endmodule

// File: verilog/tlu_serial_capture.sv
/*
 * TLU serial capture
 * Oversamples the trigger line into a shift register and, on the
 * latch strobe, picks one sample per TLU clock period to rebuild
 * the trigger number in the configured bit order.
 */

`timescale 1ns/1ps

module tlu_serial_capture
    import tlu_cfg_pkg::*;
    import tlu_event_pkg::*;
#(
    parameter int DIVISOR = 12
) (
    input  logic            CLK,
    input  logic            tlu_trigger,
    input  logic            latch_strobe,
    input  tlu_cfg_t        cfg,
    output trigger_number_t trigger_number,
    output logic            trigger_number_ready
);

    localparam int SR_W = TLU_MAX_BITS * DIVISOR;

    logic [SR_W-1:0]         sample_sr;
    logic [TLU_MAX_BITS-1:0] slot_bits;
    logic [5:0]              nbits;
    trigger_number_t         extracted;

    assign nbits = tlu_frame_bits(cfg);

    // one sample of the line per CLK cycle
    always_ff @(posedge CLK)
    begin
        sample_sr <= {sample_sr[SR_W-2:0], tlu_trigger};
    end

    // slot 0 is the most recent TLU clock period, mid-slot sample
    always_comb
    begin
        for (int s = 0; s < TLU_MAX_BITS; s++)
            slot_bits[s] = sample_sr[s * DIVISOR + DIVISOR / 2];
    end

    // earliest slot of the frame carries no data and is dropped
    always_comb
    begin
        extracted = '0;
        for (int n = 0; n < TLU_MAX_BITS - 1; n++)
        begin
            if (n < int'(nbits) - 1)
            begin
                if (cfg.msb_first)
                    extracted[n] = slot_bits[n];
                else
                    extracted[n] = slot_bits[int'(nbits) - 2 - n];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        trigger_number_ready <= latch_strobe;
        if (latch_strobe)
            trigger_number <= extracted;
    end

    a_single_latch: assert property (
        @(posedge CLK) latch_strobe |=> !latch_strobe
    ) else $error("latch strobe held for more than one cycle");

endmodule

// File: verilog/tlu_handshake_fsm.sv
/*
 * TLU handshake FSM
 * Accepts a trigger, pulses the start flag to the command block and
 * runs the mode dependent handshake: wait for trigger low, send the
 * TLU clock and latch the serial trigger number. Drives busy, veto,
 * clock enable and the two error flags.
 */

`timescale 1ns/1ps

module tlu_handshake_fsm
    import tlu_cfg_pkg::*;
    import tlu_event_pkg::*;
#(
    parameter int DIVISOR = 12
) (
    input  logic        CLK,
    input  logic        RESET,
    input  tlu_cfg_t    cfg,
    input  logic        cmd_ready,
    input  logic        ext_start_enable,
    input  logic        ext_veto,
    input  logic        fifo_near_full,
    input  logic        tlu_trigger,
    input  logic        tlu_trigger_flag,
    input  logic        word_pending,
    output logic        cmd_ext_start_flag,
    output logic        start_strobe,
    output logic        latch_strobe,
    output tlu_status_t status,
    output tlu_error_t  errors
);

    localparam int CLK_CNT_W = $clog2(TLU_MAX_BITS * DIVISOR + 1);

    typedef enum logic [2:0] {
        IDLE              = 3'd0,
        WAIT_TRIGGER_LOW  = 3'd1,
        SEND_TLU_CLOCK    = 3'd2,
        WAIT_BEFORE_LATCH = 3'd3,
        LATCH_DATA        = 3'd4,
        WAIT_DATA_SAVED   = 3'd5
    } tlu_state_e;

    tlu_state_e state;
    tlu_state_e next;

    logic [7:0]           low_cnt;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [CLK_CNT_W-1:0] clk_target;
    logic [4:0]           delay_cnt;
    logic [4:0]           delay_target;
    logic                 accept;
    logic                 line_mode;
    logic                 veto_cond;

    // modes 2 and 3 start on the trigger line itself
    assign line_mode = (cfg.mode == TLU_SIMPLE_HANDSHAKE) || (cfg.mode == TLU_DATA_HANDSHAKE);

    assign accept = cmd_ready && ext_start_enable && !ext_veto &&
                    (tlu_trigger_flag || (tlu_trigger && line_mode));

    assign veto_cond = !ext_start_enable || (fifo_near_full && !cfg.disable_veto);

    assign clk_target   = CLK_CNT_W'(tlu_frame_bits(cfg)) * CLK_CNT_W'(DIVISOR);
    assign delay_target = 5'(cfg.data_delay) + 5'(TLU_LATCH_SYNC_CYCLES);

    // start flag doubles as the internal start strobe
    assign start_strobe = cmd_ext_start_flag;

    always_comb
    begin
        next = state;
        case (state)
            IDLE:
                if (accept)
                    next = WAIT_TRIGGER_LOW;
            WAIT_TRIGGER_LOW:
            begin
                if (!line_mode)
                    next = WAIT_DATA_SAVED;
                else if (!tlu_trigger || errors.low_timeout_error)
                    next = (cfg.mode == TLU_DATA_HANDSHAKE) ? SEND_TLU_CLOCK : WAIT_DATA_SAVED;
            end
            SEND_TLU_CLOCK:
                if (clk_cnt == clk_target)
                    next = WAIT_BEFORE_LATCH;
            WAIT_BEFORE_LATCH:
                if (delay_cnt == delay_target)
                    next = LATCH_DATA;
            LATCH_DATA:
                next = WAIT_DATA_SAVED;
            WAIT_DATA_SAVED:
                if (!word_pending && cmd_ready)
                    next = IDLE;
            default:
                next = IDLE;
        endcase
    end

    // outputs follow the next state so they line up with the transition
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state              <= IDLE;
            low_cnt            <= '0;
            clk_cnt            <= '0;
            delay_cnt          <= '0;
            cmd_ext_start_flag <= 1'b0;
            latch_strobe       <= 1'b0;
            status             <= '0;
            errors             <= '0;
        end
        else
        begin
            state              <= next;
            cmd_ext_start_flag <= (state == IDLE) && (next == WAIT_TRIGGER_LOW);
            latch_strobe       <= (next == LATCH_DATA);

            status.busy         <= (next != IDLE);
            status.clock_enable <= (next == SEND_TLU_CLOCK);
            status.veto         <= veto_cond && ((next == IDLE) || (next == LATCH_DATA) ||
                                                 (next == WAIT_DATA_SAVED));

            // counters run only while their state is held
            low_cnt   <= (next == WAIT_TRIGGER_LOW) ? low_cnt + 8'd1 : 8'd0;
            clk_cnt   <= (next == SEND_TLU_CLOCK) ? clk_cnt + 1'b1 : '0;
            delay_cnt <= (next == WAIT_BEFORE_LATCH) ? delay_cnt + 5'd1 : 5'd0;

            if (next == IDLE)
            begin
                errors.accept_error      <= tlu_trigger && ext_start_enable;
                errors.low_timeout_error <= 1'b0;
            end
            else if ((next == WAIT_TRIGGER_LOW) && (cfg.low_timeout != 8'd0) &&
                     (low_cnt == cfg.low_timeout))
            begin
                // sticky until back in idle
                errors.low_timeout_error <= 1'b1;
            end
        end
    end

    a_clock_needs_busy: assert property (
        @(posedge CLK) disable iff (RESET) status.clock_enable |-> status.busy
    ) else $error("TLU clock enabled while not busy");

    a_latch_mode3: assert property (
        @(posedge CLK) disable iff (RESET) latch_strobe |-> (cfg.mode == TLU_DATA_HANDSHAKE)
    ) else $error("latch strobe outside data handshake mode");

    a_state_legal: assert property (
        @(posedge CLK) disable iff (RESET)
        state inside {IDLE, WAIT_TRIGGER_LOW, SEND_TLU_CLOCK, WAIT_BEFORE_LATCH,
                      LATCH_DATA, WAIT_DATA_SAVED}
    ) else $error("FSM in illegal state");

endmodule

// File: verilog/tlu_event_pkg.sv
/*
 * TLU event package
 * Timestamp, trigger number, FIFO word layout and the status and
 * error flag groups reported by the controller.
 */

package tlu_event_pkg;

    typedef logic [30:0] timestamp_t;

    typedef logic [31:0] trigger_number_t;

    // one word towards the readout FIFO, marker flags a trigger word
    typedef struct packed {
        logic        marker;
        logic [30:0] payload;
    } fifo_word_t;

    typedef struct packed {
        logic busy;
        logic clock_enable;
        logic veto;
    } tlu_status_t;

    typedef struct packed {
        logic accept_error;
        logic low_timeout_error;
    } tlu_error_t;

endpackage

// File: verilog/tlu_cfg_pkg.sv
/*
 * TLU configuration package
 * Trigger mode encoding, the static configuration word and the fixed
 * limits of the serial trigger-number frame.
 */

package tlu_cfg_pkg;

    // trigger handshake modes
    typedef enum logic [1:0] {
        TLU_NO_HANDSHAKE     = 2'd0,
        TLU_NO_HANDSHAKE_ALT = 2'd1,
        TLU_SIMPLE_HANDSHAKE = 2'd2,
        TLU_DATA_HANDSHAKE   = 2'd3
    } tlu_mode_e;

    // static while the controller is enabled
    typedef struct packed {
        tlu_mode_e   mode;
        logic [7:0]  low_timeout;
        logic [4:0]  clock_cycles;
        logic [3:0]  data_delay;
        logic        msb_first;
        logic        disable_veto;
        logic        write_timestamp;
    } tlu_cfg_t;

    // longest serial frame in TLU clock periods
    localparam int TLU_MAX_BITS = 32;

    // minimum delay between clock stop and latch, covers input sync
    localparam int TLU_LATCH_SYNC_CYCLES = 4;

    // clock_cycles of 0 selects a full frame
    function automatic logic [5:0] tlu_frame_bits(input tlu_cfg_t cfg);
        logic [5:0] bits;
        bits = (cfg.clock_cycles == 5'd0) ? 6'(TLU_MAX_BITS) : {1'b0, cfg.clock_cycles};
        return bits;
    endfunction

endpackage
